//--- bench/macAssert_chk.sv
`timescale 1ns/1ps

module macAssertChk
  import macPkg::*;
(
  input logic clk,
  input logic rstN,
  input logic issue,
  input logic resultValid,
  input accT  mr
);

  int failCount = 0;                // Assertion failures seen so far

  // One result per issue, exactly two edges later
  validLatency: assert property (@(posedge clk) disable iff (!rstN)
    resultValid == $past(issue, 2))
    else begin
      failCount++;
      $error("resultValid does not follow issue by two edges");
    end

  resetClean: assert property (@(posedge clk) $rose(rstN) |-> !resultValid)
    else begin
      failCount++;
      $error("resultValid is set right after reset");
    end

  // MR only moves together with a result
  mrHold: assert property (@(posedge clk) disable iff (!rstN)
    !resultValid |-> $stable(mr))
    else begin
      failCount++;
      $error("mr changed without resultValid");
    end

endmodule

bind macTop macAssertChk uAssert (
  .clk         (clk),
  .rstN        (rstN),
  .issue       (issue),
  .resultValid (resultValid),
  .mr          (mr)
);

//--- bench/macTb.sv
`timescale 1ns/1ps

module macTb
  import macPkg::*;
;

  localparam int cornerCount  = 64;     // 16 pairs in four signedness combinations
  localparam int randMpyCount = 24;
  localparam int chainLen     = 40;
  localparam int fracCount    = 33;
  localparam int rndCount     = 24;
  localparam int idleCount    = 6;
  localparam int plannedInstr = cornerCount + randMpyCount + chainLen + fracCount +
                                rndCount + idleCount;
  localparam int watchdogCycles = plannedInstr * 2 + 200;

  logic     clk;
  logic     rstN;
  logic     resetReq;
  logic     issue;
  macInstrT instr;
  accT      mr;
  logic     resultValid;

  accT         modelMr = '0;            // Running MR of the reference model
  accT         heldMr = '0;             // Last MR that should be visible
  accT         expQ[$];
  int unsigned dueQ[$];                 // Edge count at which each result is due
  int unsigned edgeCnt = 0;
  int          errCount = 0;
  int          passedTests = 0;
  int          failedTests = 0;

  macTbClock uClock (.clk(clk), .rstN(rstN), .resetReq(resetReq));

  macTop UUT (
    .clk         (clk),
    .rstN        (rstN),
    .issue       (issue),
    .instr       (instr),
    .mr          (mr),
    .resultValid (resultValid)
  );

  always @(posedge clk) edgeCnt <= edgeCnt + 1;

  task automatic checkMr(input string name, input accT got, input accT exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s = 0x%010h, expected 0x%010h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkValid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      errCount++;
    end
  endtask

  // Expected MR from the operation rules with a 40-bit wrap
  function automatic accT expectedMr(input accT acc, input macInstrT ins);
    logic signed [63:0] xs;
    logic signed [63:0] ys;
    logic signed [63:0] prod;
    logic signed [63:0] sum;
    xs = ins.unsignX ? {48'b0, ins.x} : {{48{ins.x[15]}}, ins.x};
    ys = ins.unsignY ? {48'b0, ins.y} : {{48{ins.y[15]}}, ins.y};
    prod = xs * ys;
    if (ins.fracMode) begin
      prod = prod + prod;               // Fractional product is doubled
    end
    case (ins.op)
      opMpy:   sum = prod;
      opMac:   sum = {24'b0, acc} + prod;
      default: sum = {24'b0, acc} - prod;
    endcase
    if (ins.rnd) begin
      sum = sum + 64'sd32768;
      sum[15:0] = '0;
    end
    return sum[39:0];
  endfunction

  function automatic macInstrT makeInstr(input opWordT x, input opWordT y, input logic ux,
                                         input logic uy, input logic frac, input logic rnd,
                                         input macOpT op);
    macInstrT r;
    r = '{x: x, y: y, unsignX: ux, unsignY: uy, fracMode: frac, rnd: rnd, op: op};
    return r;
  endfunction

  function automatic macOpT randomOp(input logic withMpy);
    int unsigned k;
    k = withMpy ? $urandom_range(2, 0) : $urandom_range(2, 1);
    return (k == 0) ? opMpy : (k == 1) ? opMac : opMsu;
  endfunction

  // Drives one instruction for a single cycle and queues its expected result
  task automatic issueInstr(input macInstrT ins);
    modelMr = expectedMr(modelMr, ins);
    expQ.push_back(modelMr);
    dueQ.push_back(edgeCnt + 2);
    issue = 1'b1;
    instr = ins;
    @(posedge clk);
    #1;
    issue = 1'b0;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drainResults();
    while (expQ.size() != 0) begin
      @(posedge clk);
      #1;
    end
    idleCycles(1);
  endtask

  task automatic finishTest(input string name, input int errStart);
    if (errCount == errStart) begin
      passedTests++;
      $display("Test %s: ok", name);
    end else begin
      failedTests++;
      $display("Test %s: %0d errors", name, errCount - errStart);
    end
  endtask

  // Result strobe and held MR compared on the falling edge
  always @(negedge clk) begin
    logic due;
    if (rstN) begin
      due = (dueQ.size() != 0) && (dueQ[0] == edgeCnt);
      checkValid("resultValid", resultValid, due);
      if (due) begin
        heldMr = expQ.pop_front();
        void'(dueQ.pop_front());
      end
      checkMr("mr", mr, heldMr);
    end else begin
      heldMr = '0;
    end
  end

  task automatic multiplyInteger();
    opWordT corners [4] = '{16'h8000, 16'h7fff, 16'hffff, 16'h0000};
    int errStart;
    errStart = errCount;
    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          issueInstr(makeInstr(corners[i], corners[j], s[0], s[1], 1'b0, 1'b0, opMpy));
        end
      end
    end
    for (int k = 0; k < randMpyCount; k++) begin
      issueInstr(makeInstr(opWordT'($urandom), opWordT'($urandom), 1'($urandom),
                           1'($urandom), 1'b0, 1'b0, opMpy));
    end
    drainResults();
    finishTest("multiply integer", errStart);
  endtask

  task automatic accumulateChain();
    int errStart;
    errStart = errCount;
    issueInstr(makeInstr(opWordT'($urandom), opWordT'($urandom), 1'b0, 1'b0, 1'b0, 1'b0,
                         opMpy));
    for (int k = 1; k < chainLen; k++) begin
      issueInstr(makeInstr(opWordT'($urandom), opWordT'($urandom), 1'($urandom),
                           1'($urandom), 1'b0, 1'b0, randomOp(1'b0)));
    end
    drainResults();
    finishTest("accumulate chain", errStart);
  endtask

  task automatic fractionalProducts();
    opWordT corners [4] = '{16'h8000, 16'h7fff, 16'hffff, 16'h0000};
    int errStart;
    errStart = errCount;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        issueInstr(makeInstr(corners[i], corners[j], 1'b0, 1'b0, 1'b1, 1'b0, opMpy));
      end
    end
    issueInstr(makeInstr(16'h0, 16'h0, 1'b0, 1'b0, 1'b1, 1'b0, opMpy));
    // Subtracting 2**31 from zero wraps into the guard bits
    repeat (8) issueInstr(makeInstr(16'h8000, 16'h8000, 1'b0, 1'b0, 1'b1, 1'b0, opMsu));
    for (int k = 0; k < 8; k++) begin
      issueInstr(makeInstr(opWordT'($urandom), opWordT'($urandom), 1'($urandom),
                           1'($urandom), 1'b1, 1'b0, randomOp(1'b0)));
    end
    drainResults();
    finishTest("fractional", errStart);
  endtask

  task automatic roundingCases();
    int errStart;
    errStart = errCount;
    issueInstr(makeInstr(16'h0001, 16'h8000, 1'b0, 1'b0, 1'b0, 1'b1, opMpy));  // Rounds to 0
    issueInstr(makeInstr(16'h0001, 16'h8000, 1'b1, 1'b1, 1'b0, 1'b1, opMpy));  // Carries up
    issueInstr(makeInstr(16'h4000, 16'h0001, 1'b0, 1'b0, 1'b1, 1'b1, opMpy));
    issueInstr(makeInstr(16'h7fff, 16'h7fff, 1'b0, 1'b0, 1'b1, 1'b1, opMac));
    for (int k = 4; k < rndCount; k++) begin
      issueInstr(makeInstr(opWordT'($urandom), opWordT'($urandom), 1'($urandom),
                           1'($urandom), 1'($urandom), 1'b1, randomOp(1'b1)));
    end
    drainResults();
    finishTest("rounding", errStart);
  endtask

  task automatic idleAndReset();
    int errStart;
    errStart = errCount;
    issueInstr(makeInstr(16'h1234, 16'h0567, 1'b0, 1'b0, 1'b0, 1'b0, opMpy));
    idleCycles(6);                       // MR must hold here
    issueInstr(makeInstr(16'hfedc, 16'h0321, 1'b0, 1'b1, 1'b0, 1'b0, opMac));
    idleCycles(4);
    issueInstr(makeInstr(16'h0777, 16'h9abc, 1'b1, 1'b0, 1'b0, 1'b0, opMsu));
    drainResults();
    // Reset hits while one result is showing and the next is in execute
    issueInstr(makeInstr(16'h4321, 16'h1357, 1'b0, 1'b0, 1'b0, 1'b0, opMac));
    issueInstr(makeInstr(16'h2468, 16'h0abc, 1'b0, 1'b0, 1'b0, 1'b0, opMac));
    resetReq = 1'b1;
    expQ.delete();
    dueQ.delete();
    modelMr = '0;
    idleCycles(8);
    resetReq = 1'b0;
    idleCycles(1);
    checkMr("mr", mr, '0);
    checkValid("resultValid", resultValid, 1'b0);
    issueInstr(makeInstr(16'h00ff, 16'h0101, 1'b1, 1'b1, 1'b0, 1'b0, opMac));
    drainResults();
    finishTest("idle and reset", errStart);
  endtask

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not complete", watchdogCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(32'he19f));
    issue    = 1'b0;
    instr    = '0;
    resetReq = 1'b0;
    @(posedge clk);
    while (rstN !== 1'b1) @(posedge clk);
    #1;
    checkMr("mr", mr, '0);
    checkValid("resultValid", resultValid, 1'b0);
    multiplyInteger();
    accumulateChain();
    fractionalProducts();
    roundingCases();
    idleAndReset();
    $display("Summary: %0d tests passed, %0d tests failed, %0d assertion failures",
             passedTests, failedTests, UUT.uAssert.failCount);
    if (failedTests == 0 && errCount == 0 && UUT.uAssert.failCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- bench/macTbClock.sv
`timescale 1ns/1ps

module macTbClock (
  output logic clk,
  output logic rstN,
  input  logic resetReq             // Extra reset from the test sequence
);

  logic initDone;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;          // 8 ns period
  end

  initial begin
    initDone = 1'b0;
    repeat (8) @(posedge clk);
    #1 initDone = 1'b1;
  end

  assign rstN = initDone & ~resetReq;

endmodule

//--- compile.f
src/macPkg.sv
src/macDecode.sv
src/boothPartialProducts.sv
src/csaReduction.sv
src/macAccumulator.sv
src/macTop.sv
bench/macTbClock.sv
bench/macAssert_chk.sv
bench/macTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module macTb -Mdir obj_dir -f compile.f \
  && ./obj_dir/VmacTb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log 2>/dev/null \
  && echo "Simulation run passed" \
  || { echo "Simulation run failed"; exit 1; }

//--- src/boothPartialProducts.sv
`timescale 1ns/1ps

module boothPartialProducts
  import macPkg::*;
(
  input  macCtrlT  ctrl,
  input  opWordT   xE,
  input  opWordT   yE,
  input  accT      mrIn,
  output ppBundleT pp
);

  logic   xSign;
  ppRowT  x1p;
  ppRowT  x2p;
  ppRowT  x1m;
  ppRowT  x2m;
  logic [opWidth:0] yExt;
  rowSubT sel1p;
  rowSubT sel2p;
  rowSubT sel1m;
  rowSubT sel2m;
  logic   corrP;
  logic   corrM;
  ppRowT [ppRows-1:0] rows;
  negCarryT cin;
  guardT  mrGuard;
  opWordT mrHi;
  opWordT mrLo;
  logic   rndHalf;
  logic   rndFull;
  logic [accWidth-rndBit:0] mrHigh;
  opWordT mrLow;

  // X multiples, negatives are one's complement and finished by cin
  assign xSign = ~ctrl.unsignX & xE[opWidth-1];
  assign x1p   = {xSign, xSign, xE};
  assign x2p   = {x1p[opWidth:0], 1'b0};
  assign x1m   = ~x1p;
  assign x2m   = {x1m[opWidth:0], 1'b0};   // -2X-2, carry adds 2 back

  assign yExt = {yE, 1'b0};                // Implicit y[-1] = 0

  // Booth encode of each overlapping triplet
  always_comb begin
    logic [2:0] trip;
    logic p1;
    logic p2;
    logic m1;
    logic m2;
    for (int i = 0; i < ppRows - 1; i++) begin
      trip = yExt[2*i+2 -: 3];
      p1   = ~trip[2] & (trip[1] ^ trip[0]);
      p2   = ~trip[2] & trip[1] & trip[0];
      m1   = trip[2] & (trip[1] ^ trip[0]);
      m2   = trip[2] & ~(trip[1] | trip[0]);
      sel1p[i] = ctrl.rowSub[i] ? m1 : p1;   // Subtract swaps the sign of the digit
      sel2p[i] = ctrl.rowSub[i] ? m2 : p2;
      sel1m[i] = ctrl.rowSub[i] ? p1 : m1;
      sel2m[i] = ctrl.rowSub[i] ? p2 : m2;
    end
  end

  // Unsigned Y with the top bit set needs one more X at 2**16
  assign corrP = ctrl.unsignY & yE[opWidth-1] & ~ctrl.rowSub[ppRows-2];
  assign corrM = ctrl.unsignY & yE[opWidth-1] & ctrl.rowSub[ppRows-2];

  always_comb begin
    for (int i = 0; i < ppRows - 1; i++) begin
      rows[i] = ({(opWidth + 2){sel1p[i]}} & x1p) |
                ({(opWidth + 2){sel2p[i]}} & x2p) |
                ({(opWidth + 2){sel1m[i]}} & x1m) |
                ({(opWidth + 2){sel2m[i]}} & x2m);  // No select gives zero
      cin[2*i]   = sel1m[i];
      cin[2*i+1] = sel2m[i];
    end
    rows[ppRows-1]     = ({(opWidth + 2){corrP}} & x1p) | ({(opWidth + 2){corrM}} & x1m);
    cin[2*(ppRows-1)]  = corrM;
  end

  // MR feedback only for the accumulating kinds
  assign {mrGuard, mrHi, mrLo} = mrIn & {accWidth{ctrl.macOp}};

  // Rounding constant, one bit lower in fractional mode before the doubling
  assign rndHalf = ctrl.fracMode & ctrl.rnd;
  assign rndFull = ~ctrl.fracMode & ctrl.rnd;

  assign mrLow = ctrl.mzero    ? '0 :
                 ctrl.fracMode ? {1'b0, mrLo[opWidth-1:1]} : mrLo;

  assign mrHigh = ctrl.mzero    ? {(accWidth - rndBit - 1)'(0), rndFull, rndHalf} :
                  ctrl.fracMode ? {mrGuard[$bits(guardT)-1], mrGuard, mrHi, ctrl.rnd} :
                                  {mrGuard, mrHi, ctrl.rnd, 1'b0};

  assign pp = {rows, cin, mrHigh, mrLow};

endmodule

//--- src/csaReduction.sv
`timescale 1ns/1ps

module csaReduction
  import macPkg::*;
(
  input  ppBundleT pp,
  output accT      sumVec,
  output accT      carryVec
);

  typedef struct packed {
    accT s;
    accT c;
  } csaOutT;

  localparam int numOpd = ppRows + 3;     // Rows, cin word, two feedback words

  accT    opd [numOpd];
  csaOutT l1 [4];
  csaOutT l2 [2];
  csaOutT l3 [2];
  csaOutT l4;
  csaOutT l5;

  // Full-adder slice across the whole word
  function automatic csaOutT compress(input accT a, input accT b, input accT c);
    csaOutT r;
    r.s = a ^ b ^ c;
    r.c = ((a & b) | (a & c) | (b & c)) << 1;
    return r;
  endfunction

  // Sign-extend every row to full width and place it at its weight
  always_comb begin
    for (int i = 0; i < ppRows; i++) begin
      opd[i] = {{(accWidth - opWidth - 2){pp.rows[i][opWidth+1]}}, pp.rows[i]} << (2 * i);
    end
    opd[ppRows]     = {(accWidth - $bits(negCarryT))'(0), pp.cin};
    opd[ppRows + 1] = {pp.mrHigh, (rndBit - 1)'(0)};       // Starts at bit 14
    opd[ppRows + 2] = {(accWidth - opWidth)'(0), pp.mrLow};
  end

  // Twelve operands down to two in five levels
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      l1[k] = compress(opd[3*k], opd[3*k+1], opd[3*k+2]);
    end
    l2[0] = compress(l1[0].s, l1[0].c, l1[1].s);
    l2[1] = compress(l1[1].c, l1[2].s, l1[2].c);
    l3[0] = compress(l2[0].s, l2[0].c, l2[1].s);
    l3[1] = compress(l2[1].c, l1[3].s, l1[3].c);  // Level-one leftovers join here
    l4    = compress(l3[0].s, l3[0].c, l3[1].s);
    l5    = compress(l4.s, l4.c, l3[1].c);
  end

  assign sumVec   = l5.s;
  assign carryVec = l5.c;

endmodule

//--- src/macAccumulator.sv
`timescale 1ns/1ps

module macAccumulator
  import macPkg::*;
(
  input  logic    clk,
  input  logic    rstN,
  input  logic    valE,
  input  macCtrlT ctrl,
  input  accT     sumVec,
  input  accT     carryVec,
  output accT     mr,
  output logic    resultValid
);

  accT rawSum;
  accT nextMr;

  // Carry-propagate add, wraps at 40 bits
  assign rawSum = sumVec + carryVec;

  always_comb begin
    nextMr = rawSum;
    if (ctrl.fracMode) begin
      // Feedback entered halved, so MR bit 0 comes back here
      nextMr = {rawSum[accWidth-2:0], ctrl.macOp & mr[0]};
    end
    if (ctrl.rnd) begin
      nextMr[rndBit:0] = '0;               // Low word cleared after the 2**15 add
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mr          <= '0;
      resultValid <= 1'b0;
    end else begin
      resultValid <= valE;                 // One pulse per instruction
      if (valE) begin
        mr <= nextMr;
      end
    end
  end

endmodule

//--- src/macDecode.sv
`timescale 1ns/1ps

module macDecode
  import macPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  logic     issue,
  input  macInstrT instr,
  output macCtrlT  ctrl,
  output opWordT   xE,
  output opWordT   yE,
  output logic     valE
);

  macCtrlT ctrlNext;

  // Operation kind turned into datapath controls
  always_comb begin
    ctrlNext          = '0;
    ctrlNext.mzero    = (instr.op == opMpy);
    ctrlNext.macOp    = (instr.op == opMac) || (instr.op == opMsu);
    ctrlNext.rowSub   = {$bits(rowSubT){instr.op == opMsu}};  // All rows negated for MSU
    ctrlNext.fracMode = instr.fracMode;
    ctrlNext.rnd      = instr.rnd;
    ctrlNext.unsignX  = instr.unsignX;
    ctrlNext.unsignY  = instr.unsignY;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valE <= 1'b0;
      ctrl <= '0;
    end else begin
      valE <= issue;                 // Idle cycles leave the stage empty
      if (issue) begin
        ctrl <= ctrlNext;
      end
    end
  end

  // Operands only move on an issue
  always_ff @(posedge clk) begin
    if (issue) begin
      xE <= instr.x;
      yE <= instr.y;
    end
  end

endmodule

//--- src/macPkg.sv
package macPkg;

  localparam int accWidth = 40;    // Guard + high word + low word
  localparam int opWidth  = 16;
  localparam int ppRows   = 9;     // Eight Booth rows plus the unsigned-Y row
  localparam int rndBit   = 15;    // Weight of the rounding constant in MR

  typedef logic [opWidth-1:0] opWordT;
  typedef logic [accWidth-2*opWidth-1:0] guardT;
  typedef logic [accWidth-1:0] accT;

  // One Booth row, operand plus two bits of sign room for the 2X case
  typedef logic [opWidth+1:0] ppRowT;

  // One bit per digit position, bit 2i for -X and bit 2i+1 for -2X
  typedef logic [2*(ppRows-1):0] negCarryT;

  typedef logic [ppRows-2:0] rowSubT;

  typedef enum logic [1:0] {
    opMpy,                         // MR = X*Y
    opMac,                         // MR = MR + X*Y
    opMsu                          // MR = MR - X*Y
  } macOpT;

  typedef struct packed {
    opWordT x;
    opWordT y;
    logic   unsignX;
    logic   unsignY;
    logic   fracMode;              // Product doubled
    logic   rnd;
    macOpT  op;
  } macInstrT;

  typedef struct packed {
    logic   mzero;                 // Plain multiply, MR feedback forced to zero
    rowSubT rowSub;                // Swaps the Booth selects row by row
    logic   macOp;                 // MR feedback enabled
    logic   fracMode;
    logic   rnd;
    logic   unsignX;
    logic   unsignY;
  } macCtrlT;

  typedef struct packed {
    ppRowT [ppRows-1:0]        rows;    // Row i carries weight 4**i
    negCarryT                  cin;
    logic [accWidth-rndBit:0]  mrHigh;  // MR feedback bits 39..14
    opWordT                    mrLow;   // MR feedback bits 15..0
  } ppBundleT;

endpackage

//--- src/macTop.sv
`timescale 1ns/1ps

module macTop
  import macPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  logic     issue,
  input  macInstrT instr,
  output accT      mr,
  output logic     resultValid
);

  macCtrlT  ctrl;
  opWordT   xE;
  opWordT   yE;
  logic     valE;
  ppBundleT pp;
  accT      sumVec;
  accT      carryVec;

  macDecode uDecode (
    .clk   (clk),
    .rstN  (rstN),
    .issue (issue),
    .instr (instr),
    .ctrl  (ctrl),
    .xE    (xE),
    .yE    (yE),
    .valE  (valE)
  );

  // Current MR fed straight back so back-to-back MACs chain
  boothPartialProducts uBooth (.ctrl(ctrl), .xE(xE), .yE(yE), .mrIn(mr), .pp(pp));

  csaReduction uCsa (.pp(pp), .sumVec(sumVec), .carryVec(carryVec));

  macAccumulator uAcc (
    .clk         (clk),
    .rstN        (rstN),
    .valE        (valE),
    .ctrl        (ctrl),
    .sumVec      (sumVec),
    .carryVec    (carryVec),
    .mr          (mr),
    .resultValid (resultValid)
  );

endmodule
